//--- rtl/isa_pkg.sv
package isa_pkg;

  typedef logic [31:0] data_t;
  typedef logic [4:0]  reg_idx_t;

  // low field is either imm[15:0] or {rd, shamt, 6 spare bits}
  typedef struct packed {
    logic [5:0]  opcode;
    reg_idx_t    rs;
    reg_idx_t    rt;
    logic [15:0] low;
  } instr_t;

  // 6'h00 left undefined so an all-zero word is a no-op
  typedef enum logic [5:0] {
    OP_ADD  = 6'h01,
    OP_SUB  = 6'h02,
    OP_AND  = 6'h03,
    OP_OR   = 6'h04,
    OP_XOR  = 6'h05,
    OP_SLT  = 6'h06,
    OP_SLL  = 6'h07,
    OP_ADDI = 6'h08,
    OP_ANDI = 6'h09,
    OP_ORI  = 6'h0a
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL
  } alu_op_e;

  typedef struct packed {
    alu_op_e alu_op;
    logic    alu_src;
    logic    reg_dst;
    logic    reg_write;
  } ctrl_t;

  function automatic reg_idx_t instr_rd(instr_t instr);
    return instr.low[15:11];
  endfunction

  function automatic logic [4:0] instr_shamt(instr_t instr);
    return instr.low[10:6];
  endfunction

endpackage

//--- rtl/pipe_pkg.sv
package pipe_pkg;

  import isa_pkg::*;

  ////////////////////
  // decode -> execute
  ////////////////////

  // imm already zero-extended to a full word
  typedef struct packed {
    logic       valid;
    ctrl_t      ctrl;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   dest;
    data_t      op_a;
    data_t      op_b;
    data_t      imm;
    logic [4:0] shamt;
  } id_ex_t;

  ////////////////////
  // execute -> writeback
  ////////////////////

  typedef struct packed {
    logic     valid;
    logic     reg_write;
    reg_idx_t dest;
    data_t    result;
  } ex_wb_t;

  // regfile write port and core output
  typedef struct packed {
    reg_idx_t dest;
    data_t    data;
  } wb_t;

endpackage

//--- rtl/register_file.sv
`timescale 1ns/10ps

module register_file (
  input  logic              clk,
  input  logic              rst_n,
  input  isa_pkg::reg_idx_t rd_addr_a,
  input  isa_pkg::reg_idx_t rd_addr_b,
  output isa_pkg::data_t    rd_data_a,
  output isa_pkg::data_t    rd_data_b,
  input  logic              wr_en,
  input  pipe_pkg::wb_t     wr
);

  import isa_pkg::*;

  data_t regs [32];

  // r0 hardwired, then same-cycle write bypass, then storage
  function automatic data_t read_port(reg_idx_t addr);
    if (addr == '0) begin
      return '0;
    end
    if (wr_en && (wr.dest == addr)) begin
      return wr.data;
    end
    return regs[addr];
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr.dest] <= wr.data;
    end
  end

  always_comb begin
    rd_data_a = read_port(rd_addr_a);
    rd_data_b = read_port(rd_addr_b);
  end

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               instr_valid,
  input  isa_pkg::instr_t    instr,
  output isa_pkg::reg_idx_t  rd_addr_a,
  output isa_pkg::reg_idx_t  rd_addr_b,
  input  isa_pkg::data_t     rd_data_a,
  input  isa_pkg::data_t     rd_data_b,
  output pipe_pkg::id_ex_t   id_ex
);

  import isa_pkg::*;
  import pipe_pkg::*;

  ctrl_t  ctrl;
  id_ex_t id_ex_next;

  // opcode-only control decode
  function automatic ctrl_t decode_ctrl(logic [5:0] opcode);
    ctrl_t c;
    c = '{alu_op: ALU_ADD, alu_src: 1'b0, reg_dst: 1'b1, reg_write: 1'b1};
    case (opcode)
      OP_ADD:  c.alu_op = ALU_ADD;
      OP_SUB:  c.alu_op = ALU_SUB;
      OP_AND:  c.alu_op = ALU_AND;
      OP_OR:   c.alu_op = ALU_OR;
      OP_XOR:  c.alu_op = ALU_XOR;
      OP_SLT:  c.alu_op = ALU_SLT;
      OP_SLL:  c.alu_op = ALU_SLL;
      // i-type writes rt and takes the immediate as operand b
      OP_ADDI: c = '{alu_op: ALU_ADD, alu_src: 1'b1, reg_dst: 1'b0, reg_write: 1'b1};
      OP_ANDI: c = '{alu_op: ALU_AND, alu_src: 1'b1, reg_dst: 1'b0, reg_write: 1'b1};
      OP_ORI:  c = '{alu_op: ALU_OR,  alu_src: 1'b1, reg_dst: 1'b0, reg_write: 1'b1};
      default: c.reg_write = 1'b0;
    endcase
    return c;
  endfunction

  assign rd_addr_a = instr.rs;
  assign rd_addr_b = instr.rt;

  assign ctrl = decode_ctrl(instr.opcode);

  always_comb begin
    id_ex_next.valid = instr_valid;
    id_ex_next.ctrl  = ctrl;
    id_ex_next.rs    = instr.rs;
    id_ex_next.rt    = instr.rt;
    id_ex_next.dest  = ctrl.reg_dst ? instr_rd(instr) : instr.rt;
    // r0 is never written
    if (id_ex_next.dest == '0) begin
      id_ex_next.ctrl.reg_write = 1'b0;
    end
    id_ex_next.op_a  = rd_data_a;
    id_ex_next.op_b  = rd_data_b;
    id_ex_next.imm   = {16'h0000, instr.low};
    id_ex_next.shamt = instr_shamt(instr);
  end

  ////////////////////
  // id/ex register
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_ex <= '0;
    end else begin
      id_ex <= id_ex_next;
    end
  end

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
  input  logic             clk,
  input  logic             rst_n,
  input  pipe_pkg::id_ex_t id_ex,
  output pipe_pkg::ex_wb_t ex_wb
);

  import isa_pkg::*;
  import pipe_pkg::*;

  logic   fwd_a;
  logic   fwd_b;
  data_t  op_a;
  data_t  op_b_reg;
  data_t  op_b;
  data_t  result;
  ex_wb_t ex_wb_next;

  ////////////////////
  // forwarding
  ////////////////////

  // distance-1 bypass from our own output register
  // distance 2 is covered by the regfile write-through
  assign fwd_a = ex_wb.valid && ex_wb.reg_write && (ex_wb.dest == id_ex.rs);
  assign fwd_b = ex_wb.valid && ex_wb.reg_write && (ex_wb.dest == id_ex.rt);

  assign op_a     = fwd_a ? ex_wb.result : id_ex.op_a;
  assign op_b_reg = fwd_b ? ex_wb.result : id_ex.op_b;

  // immediate mux after the bypass
  assign op_b = id_ex.ctrl.alu_src ? id_ex.imm : op_b_reg;

  ////////////////////
  // alu
  ////////////////////

  always_comb begin
    case (id_ex.ctrl.alu_op)
      ALU_ADD: result = op_a + op_b;
      ALU_SUB: result = op_a - op_b;
      ALU_AND: result = op_a & op_b;
      ALU_OR:  result = op_a | op_b;
      ALU_XOR: result = op_a ^ op_b;
      // signed compare
      ALU_SLT: result = {31'b0, $signed(op_a) < $signed(op_b)};
      // shifts rt by shamt as in mips
      ALU_SLL: result = op_b << id_ex.shamt;
      default: result = '0;
    endcase
  end

  always_comb begin
    ex_wb_next.valid     = id_ex.valid;
    // a bubble still carries stale ctrl
    ex_wb_next.reg_write = id_ex.valid && id_ex.ctrl.reg_write;
    ex_wb_next.dest      = id_ex.dest;
    ex_wb_next.result    = result;
  end

  ////////////////////
  // ex/wb register
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_wb <= '0;
    end else begin
      ex_wb <= ex_wb_next;
    end
  end

endmodule

//--- rtl/cpu_core.sv
`timescale 1ns/10ps

module cpu_core (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            instr_valid,
  input  isa_pkg::instr_t instr,
  output logic            wb_valid,
  output pipe_pkg::wb_t   wb
);

  import isa_pkg::*;
  import pipe_pkg::*;

  reg_idx_t rd_addr_a;
  reg_idx_t rd_addr_b;
  data_t    rd_data_a;
  data_t    rd_data_b;
  id_ex_t   id_ex;
  ex_wb_t   ex_wb;

  // writeback is the ex/wb register itself
  assign wb_valid = ex_wb.valid && ex_wb.reg_write;
  assign wb.dest  = ex_wb.dest;
  assign wb.data  = ex_wb.result;

  decode_stage i_decode_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rd_addr_a   (rd_addr_a),
    .rd_addr_b   (rd_addr_b),
    .rd_data_a   (rd_data_a),
    .rd_data_b   (rd_data_b),
    .id_ex       (id_ex)
  );

  register_file i_register_file (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .wr_en     (wb_valid),
    .wr        (wb)
  );

  execute_stage i_execute_stage (
    .clk   (clk),
    .rst_n (rst_n),
    .id_ex (id_ex),
    .ex_wb (ex_wb)
  );

endmodule

//--- tb/cpu_core_sva.sv
`timescale 1ns/10ps

module cpu_core_sva (
  input logic          clk,
  input logic          rst_n,
  input logic          instr_valid,
  input logic          wb_valid,
  input pipe_pkg::wb_t wb
);

  // decode drops every r0 write
  assert property (@(posedge clk) disable iff (!rst_n) wb_valid |-> (wb.dest != 5'd0))
    else $error("writeback to r0");

  assert property (@(posedge clk) (!rst_n && $past(!rst_n)) |-> !wb_valid)
    else $error("writeback pulse during reset");

  // fixed two-edge latency
  assert property (@(posedge clk) disable iff (!rst_n) wb_valid |-> $past(instr_valid, 2))
    else $error("writeback without an instruction two edges earlier");

endmodule

bind cpu_core cpu_core_sva i_cpu_core_sva (
  .clk         (clk),
  .rst_n       (rst_n),
  .instr_valid (instr_valid),
  .wb_valid    (wb_valid),
  .wb          (wb)
);

//--- tb/tb_cpu_core.sv
`timescale 1ns/10ps

module tb_cpu_core;

  import isa_pkg::*;
  import pipe_pkg::*;

  localparam logic [5:0] OPC_ADD  = 6'h01;
  localparam logic [5:0] OPC_SUB  = 6'h02;
  localparam logic [5:0] OPC_AND  = 6'h03;
  localparam logic [5:0] OPC_OR   = 6'h04;
  localparam logic [5:0] OPC_XOR  = 6'h05;
  localparam logic [5:0] OPC_SLT  = 6'h06;
  localparam logic [5:0] OPC_SLL  = 6'h07;
  localparam logic [5:0] OPC_ADDI = 6'h08;
  localparam logic [5:0] OPC_ANDI = 6'h09;
  localparam logic [5:0] OPC_ORI  = 6'h0a;

  // one table row with the writeback the model expects for it
  typedef struct packed {
    logic   valid;
    instr_t instr;
    logic   wb_exp;
    wb_t    wb;
  } entry_t;

  logic   clk;
  logic   rst_n;
  logic   instr_valid;
  instr_t instr;
  logic   wb_valid;
  wb_t    wb;

  entry_t      tbl[$];
  string       desc[$];
  data_t       shadow[32];
  logic [31:0] lfsr = 32'd66390;
  int          cyc = 0;
  int          start_cyc = 1000000;
  bit          checking = 1'b0;
  bit          tbl_ready = 1'b0;
  int          errors = 0;
  int          failed = 0;

  cpu_core i_cpu_core (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb_valid    (wb_valid),
    .wb          (wb)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // galois lfsr x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic instr_t r_type(logic [5:0] op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt,
                                    logic [4:0] shamt);
    return {op, rs, rt, rd, shamt, 6'b000000};
  endfunction

  function automatic instr_t i_type(logic [5:0] op, reg_idx_t rt, reg_idx_t rs, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  ////////////////////
  // reference model
  ////////////////////

  // executes one row in table order over the shadow registers
  task automatic add_entry(logic valid, instr_t ins, string text);
    entry_t e;
    data_t  a;
    data_t  b;
    data_t  imm;
    logic   known;
    a = shadow[ins.rs];
    b = shadow[ins.rt];
    imm = {16'h0000, ins.low};
    known = 1'b1;
    e = '0;
    e.valid = valid;
    e.instr = ins;
    e.wb.dest = ins.low[15:11];
    case (ins.opcode)
      OPC_ADD:  e.wb.data = a + b;
      OPC_SUB:  e.wb.data = a - b;
      OPC_AND:  e.wb.data = a & b;
      OPC_OR:   e.wb.data = a | b;
      OPC_XOR:  e.wb.data = a ^ b;
      OPC_SLT:  e.wb.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OPC_SLL:  e.wb.data = b << ins.low[10:6];
      OPC_ADDI: e.wb.data = a + imm;
      OPC_ANDI: e.wb.data = a & imm;
      OPC_ORI:  e.wb.data = a | imm;
      default:  known = 1'b0;
    endcase
    if (ins.opcode inside {OPC_ADDI, OPC_ANDI, OPC_ORI}) begin
      e.wb.dest = ins.rt;
    end
    e.wb_exp = valid && known && (e.wb.dest != 5'd0);
    if (e.wb_exp) begin
      shadow[e.wb.dest] = e.wb.data;
    end
    tbl.push_back(e);
    desc.push_back(text);
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    foreach (shadow[i]) begin
      shadow[i] = '0;
    end
    for (int r = 1; r <= 3; r++) begin
      add_entry(1'b1, r_type(OPC_OR, 5'(r), 5'(r), 5'd0, 5'd0), "echo after reset");
    end
    // full 32-bit values in r1..r4
    for (int r = 1; r <= 4; r++) begin
      rnd = take_bits(16);
      add_entry(1'b1, i_type(OPC_ADDI, 5'(r), 5'd0, rnd[15:0]), "load upper half");
      add_entry(1'b1, r_type(OPC_SLL, 5'(r), 5'd0, 5'(r), 5'd16), "shift upper half");
      rnd = take_bits(16);
      add_entry(1'b1, i_type(OPC_ORI, 5'(r), 5'(r), rnd[15:0]), "merge lower half");
    end
    add_entry(1'b0, '0, "bubble");
    add_entry(1'b1, r_type(OPC_ADD, 5'd5, 5'd1, 5'd2, 5'd0), "add");
    add_entry(1'b1, r_type(OPC_SUB, 5'd6, 5'd1, 5'd2, 5'd0), "sub");
    add_entry(1'b1, r_type(OPC_AND, 5'd7, 5'd1, 5'd3, 5'd0), "and");
    add_entry(1'b1, r_type(OPC_OR, 5'd8, 5'd2, 5'd4, 5'd0), "or");
    add_entry(1'b1, r_type(OPC_XOR, 5'd9, 5'd3, 5'd4, 5'd0), "xor");
    add_entry(1'b1, r_type(OPC_SUB, 5'd10, 5'd0, 5'd3, 5'd0), "negate");
    add_entry(1'b1, r_type(OPC_SLT, 5'd11, 5'd10, 5'd3, 5'd0), "slt signed a");
    add_entry(1'b1, r_type(OPC_SLT, 5'd12, 5'd3, 5'd10, 5'd0), "slt signed b");
    rnd = take_bits(5);
    add_entry(1'b1, r_type(OPC_SLL, 5'd13, 5'd0, 5'd4, rnd[4:0]), "sll by shamt");
    // dependence chains
    add_entry(1'b1, r_type(OPC_ADD, 5'd14, 5'd1, 5'd2, 5'd0), "chain head");
    add_entry(1'b1, r_type(OPC_SUB, 5'd15, 5'd14, 5'd3, 5'd0), "distance 1 on rs");
    add_entry(1'b1, r_type(OPC_XOR, 5'd16, 5'd15, 5'd14, 5'd0), "distance 1 and 2");
    add_entry(1'b1, r_type(OPC_OR, 5'd17, 5'd4, 5'd16, 5'd0), "distance 1 on rt");
    add_entry(1'b1, r_type(OPC_ADD, 5'd18, 5'd3, 5'd4, 5'd0), "producer");
    add_entry(1'b0, r_type(OPC_ADD, 5'd29, 5'd1, 5'd2, 5'd0), "bubble with instr");
    add_entry(1'b1, r_type(OPC_SUB, 5'd19, 5'd18, 5'd1, 5'd0), "distance 2");
    add_entry(1'b0, '0, "bubble");
    add_entry(1'b0, '0, "bubble");
    add_entry(1'b1, r_type(OPC_AND, 5'd20, 5'd19, 5'd2, 5'd0), "distance 3");
    add_entry(1'b1, r_type(OPC_OR, 5'd28, 5'd29, 5'd0, 5'd0), "echo bubble dest");
    rnd = take_bits(16);
    add_entry(1'b1, i_type(OPC_ADDI, 5'd21, 5'd1, rnd[15:0]), "addi");
    rnd = take_bits(16);
    add_entry(1'b1, i_type(OPC_ANDI, 5'd22, 5'd2, rnd[15:0] | 16'h8000), "andi zero ext");
    add_entry(1'b1, i_type(OPC_ORI, 5'd23, 5'd0, 16'hffff), "ori zero ext");
    // r0 and undefined opcodes never write
    add_entry(1'b1, r_type(OPC_ADD, 5'd0, 5'd1, 5'd2, 5'd0), "add to r0");
    add_entry(1'b1, r_type(OPC_OR, 5'd27, 5'd0, 5'd0, 5'd0), "echo r0");
    rnd = take_bits(16);
    add_entry(1'b1, i_type(OPC_ADDI, 5'd0, 5'd3, rnd[15:0]), "addi to r0");
    add_entry(1'b1, r_type(6'h00, 5'd26, 5'd1, 5'd2, 5'd0), "undefined 00");
    add_entry(1'b1, i_type(6'h3f, 5'd26, 5'd1, 16'h1234), "undefined 3f");
    add_entry(1'b1, r_type(OPC_OR, 5'd25, 5'd26, 5'd0, 5'd0), "echo undefined dest");
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    rst_n = 1'b0;
    instr_valid = 1'b0;
    instr = '0;
    build_table();
    tbl_ready = 1'b1;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    checking = 1'b1;
    // idle cycles after reset must stay quiet
    repeat (3) @(posedge clk);
    @(negedge clk);
    start_cyc = cyc;
    foreach (tbl[i]) begin
      @(posedge clk);
      instr_valid <= tbl[i].valid;
      instr <= tbl[i].instr;
    end
    @(posedge clk);
    instr_valid <= 1'b0;
    instr <= '0;
    repeat (4) @(negedge clk);
    @(posedge clk);
    $display("%0d tests, %0d failed, %0d errors", tbl.size(), failed, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  ////////////////////
  // monitor
  ////////////////////

  // row i is sampled at edge start+2+i and shows on wb after the next edge
  always @(negedge clk) begin : monitor
    int   idx;
    logic ok;
    idx = cyc - start_cyc - 3;
    if (checking && idx >= 0 && idx < tbl.size()) begin
      ok = 1'b1;
      if (tbl[idx].wb_exp) begin
        assert (wb_valid) else begin
          $display("%0t: test %0d produced no writeback pulse", $time, idx);
          errors++;
          ok = 1'b0;
        end
        assert (!wb_valid || wb == tbl[idx].wb) else begin
          $display("Mismatch at %0t: test %0d expected r%0d=%08h, got r%0d=%08h", $time, idx,
                   tbl[idx].wb.dest, tbl[idx].wb.data, wb.dest, wb.data);
          errors++;
          ok = 1'b0;
        end
      end else begin
        assert (!wb_valid) else begin
          $display("%0t: test %0d wrote r%0d but should not write", $time, idx, wb.dest);
          errors++;
          ok = 1'b0;
        end
      end
      if (ok) begin
        $display("test %0d %s: ok", idx, desc[idx]);
      end else begin
        $display("test %0d %s: wrong", idx, desc[idx]);
        failed++;
      end
    end else if (checking) begin
      assert (!wb_valid) else begin
        $display("%0t: writeback pulse while no instruction was in flight", $time);
        errors++;
      end
    end
  end

  initial begin : watchdog
    wait (tbl_ready);
    #((tbl.size() + 10) * 20 * 2);
    $display("timeout: run did not finish within the expected time");
    $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- project.f
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/register_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/cpu_core.sv
tb/cpu_core_sva.sv
tb/tb_cpu_core.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_cpu_core \
  -f project.f \
  -Mdir obj_dir

status=0
./obj_dir/Vtb_cpu_core > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi
exit 0
